// ==== verilog/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

	// ####################
	// Sizes
	localparam int data_w       = 8;
	localparam int instr_w      = 16;
	localparam int nregs        = 8;
	localparam int reg_aw       = 3;
	localparam int imem_depth   = 64;
	localparam int pc_w         = 6;
	localparam int clks_per_bit = 16;
	// Dump order is pc then r0 to r7
	localparam int dump_len     = 9;

	// ####################
	// Host command bytes
	localparam logic [7:0] cmd_load = 8'h4C;
	localparam logic [7:0] cmd_run  = 8'h52;
	localparam logic [7:0] cmd_step = 8'h53;
	localparam logic [7:0] resp_bad = 8'hEE;

	// ####################
	// Opcodes not listed here act as no-ops
	localparam logic [3:0] op_add  = 4'h1;
	localparam logic [3:0] op_sub  = 4'h2;
	localparam logic [3:0] op_and  = 4'h3;
	localparam logic [3:0] op_or   = 4'h4;
	localparam logic [3:0] op_xor  = 4'h5;
	localparam logic [3:0] op_li   = 4'h6;
	localparam logic [3:0] op_addi = 4'h7;
	localparam logic [3:0] op_bnz  = 4'h8;
	localparam logic [3:0] op_halt = 4'hF;

	// Debug FSM state codes
	localparam int st_w = 3;
	localparam logic [st_w-1:0] st_idle   = 3'd0;
	localparam logic [st_w-1:0] st_ld_cnt = 3'd1;
	localparam logic [st_w-1:0] st_ld_hi  = 3'd2;
	localparam logic [st_w-1:0] st_ld_lo  = 3'd3;
	localparam logic [st_w-1:0] st_run    = 3'd4;
	localparam logic [st_w-1:0] st_step   = 3'd5;
	localparam logic [st_w-1:0] st_dump   = 3'd6;
	localparam logic [st_w-1:0] st_bad    = 3'd7;

	// One instruction word in register or immediate view
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [2:0] rd;
			logic [2:0] rs;
			logic [2:0] rt;
			logic [2:0] pad;
		} r_fmt;
		struct packed {
			logic [3:0] op;
			logic [2:0] rd;
			logic [7:0] imm;
			logic       pad;
		} i_fmt;
	} instr_t;

endpackage

`default_nettype wire

// ==== verilog/dbg_ifs.sv ====
`default_nettype none
`timescale 1ns/1ps

// Byte link between the UART halves and the debug FSM
interface uart_byte_if;
	import dbg_pkg::*;

	logic [data_w-1:0] rx_data;
	logic              rx_done;
	logic [data_w-1:0] tx_data;
	logic              tx_start;
	logic              tx_done;

	modport rx (output rx_data, output rx_done);
	modport tx (input tx_data, input tx_start, output tx_done);
	modport ctrl (input rx_data, input rx_done, input tx_done, output tx_data, output tx_start);
endinterface

// Program load and run control of the core
interface core_dbg_if;
	import dbg_pkg::*;

	logic               imem_we;
	logic [pc_w-1:0]    imem_addr;
	logic [instr_w-1:0] imem_data;
	logic               core_clr;
	logic               run_en;
	logic               halted;
	logic [pc_w-1:0]    pc;

	modport ctrl (
		output imem_we, output imem_addr, output imem_data,
		output core_clr, output run_en, input halted
	);
	modport core (
		input imem_we, input imem_addr, input imem_data,
		input core_clr, input run_en, output halted, output pc
	);
endinterface

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    rx,
	uart_byte_if.rx link
);
	import dbg_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic busy;
	logic mid_bit;
	logic [$clog2(clks_per_bit)-1:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic [data_w-1:0] shreg;

	assign mid_bit = (tick_cnt == clks_per_bit / 2 - 1);
	assign link.rx_data = shreg;

	// Line synchronizer that idles high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// ####################
	// Frame timing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy         <= 1'b0;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			link.rx_done <= 1'b0;
		end else begin
			link.rx_done <= 1'b0;
			if (!busy) begin
				if (rx_prev && !rx_sync) begin
					busy     <= 1'b1;
					tick_cnt <= '0;
					bit_cnt  <= '0;
				end
			end else begin
				if (tick_cnt == clks_per_bit - 1) begin
					tick_cnt <= '0;
					bit_cnt  <= bit_cnt + 1'b1;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
				if (mid_bit) begin
					// Start bit gone high again means a glitch
					if (bit_cnt == 0 && rx_sync)
						busy <= 1'b0;
					if (bit_cnt == data_w + 1) begin
						busy         <= 1'b0;
						link.rx_done <= rx_sync;
					end
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (busy && mid_bit && bit_cnt != 0 && bit_cnt <= data_w)
			shreg <= {rx_sync, shreg[data_w-1:1]};
	end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
	input  logic    clk,
	input  logic    arst_n,
	output logic    tx,
	uart_byte_if.tx link
);
	import dbg_pkg::*;

	logic busy;
	logic [$clog2(clks_per_bit)-1:0] tick_cnt;
	logic [3:0] bit_cnt;
	// Stop, data and start bits shifted out from bit 0
	logic [data_w+1:0] frame;

	// Idle frame is all ones so the line rests high
	assign tx = frame[0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy         <= 1'b0;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			frame        <= '1;
			link.tx_done <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			if (!busy) begin
				if (link.tx_start) begin
					busy     <= 1'b1;
					tick_cnt <= '0;
					bit_cnt  <= '0;
					frame    <= {1'b1, link.tx_data, 1'b0};
				end
			end else if (tick_cnt == clks_per_bit - 1) begin
				tick_cnt <= '0;
				frame    <= {1'b1, frame[data_w+1:1]};
				if (bit_cnt == data_w + 1) begin
					// End of stop bit
					busy         <= 1'b0;
					link.tx_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mini_cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module mini_cpu (
	input  logic                      clk,
	input  logic                      arst_n,
	core_dbg_if.core                  dbg,
	input  logic [dbg_pkg::reg_aw-1:0] rd_idx,
	output logic [dbg_pkg::data_w-1:0] rd_val
);
	import dbg_pkg::*;

	logic [instr_w-1:0] imem [imem_depth];
	logic [data_w-1:0]  regs [nregs];
	logic [pc_w-1:0]    pc_q;
	logic               halted_q;

	instr_t            ir;
	logic [data_w-1:0] rs_val;
	logic [data_w-1:0] rt_val;
	logic [data_w-1:0] rd_cur;
	logic [data_w-1:0] result;
	logic              wr_en;
	logic              halt_now;
	logic [pc_w-1:0]   pc_next;

	assign dbg.pc     = pc_q;
	assign dbg.halted = halted_q;
	assign rd_val     = regs[rd_idx];

	// Program memory written only by the debug loader
	always_ff @(posedge clk) begin
		if (dbg.imem_we)
			imem[dbg.imem_addr] <= dbg.imem_data;
	end

	assign ir = imem[pc_q];

	// ####################
	// Decode and execute
	always_comb begin
		rs_val   = regs[ir.r_fmt.rs];
		rt_val   = regs[ir.r_fmt.rt];
		rd_cur   = regs[ir.i_fmt.rd];
		result   = rs_val;
		wr_en    = 1'b0;
		halt_now = 1'b0;
		pc_next  = pc_q + 1'b1;
		case (ir.r_fmt.op)
			op_add: begin
				result = rs_val + rt_val;
				wr_en  = 1'b1;
			end
			op_sub: begin
				result = rs_val - rt_val;
				wr_en  = 1'b1;
			end
			op_and: begin
				result = rs_val & rt_val;
				wr_en  = 1'b1;
			end
			op_or: begin
				result = rs_val | rt_val;
				wr_en  = 1'b1;
			end
			op_xor: begin
				result = rs_val ^ rt_val;
				wr_en  = 1'b1;
			end
			op_li: begin
				result = ir.i_fmt.imm;
				wr_en  = 1'b1;
			end
			op_addi: begin
				result = rd_cur + ir.i_fmt.imm;
				wr_en  = 1'b1;
			end
			op_bnz: begin
				if (rd_cur != '0)
					pc_next = ir.i_fmt.imm[pc_w-1:0];
			end
			op_halt: begin
				// pc stays on the halt word
				halt_now = 1'b1;
				pc_next  = pc_q;
			end
			default: ;
		endcase
	end

	// ####################
	// Architectural state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q     <= '0;
			halted_q <= 1'b0;
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;
		end else if (dbg.core_clr) begin
			pc_q     <= '0;
			halted_q <= 1'b0;
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;
		end else if (dbg.run_en && !halted_q) begin
			pc_q     <= pc_next;
			halted_q <= halt_now;
			if (wr_en)
				regs[ir.r_fmt.rd] <= result;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reg_collector.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_collector (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       start,
	input  logic                       next,
	input  logic [dbg_pkg::pc_w-1:0]   pc,
	output logic [dbg_pkg::reg_aw-1:0] rd_idx,
	input  logic [dbg_pkg::data_w-1:0] rd_val,
	output logic [dbg_pkg::data_w-1:0] byte_out
);
	import dbg_pkg::*;

	// Position within the dump
	logic [$clog2(dump_len)-1:0] idx;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			idx <= '0;
		end else if (start) begin
			idx <= '0;
		end else if (next && idx < dump_len - 1) begin
			idx <= idx + 1'b1;
		end
	end

	// Byte 0 is the pc, then one register per byte
	assign rd_idx = reg_aw'(idx - 1'b1);

	always_comb begin
		if (idx == '0)
			byte_out = {{(data_w - pc_w){1'b0}}, pc};
		else
			byte_out = rd_val;
	end

endmodule

`default_nettype wire

// ==== verilog/debug_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module debug_fsm (
	input  logic                       clk,
	input  logic                       arst_n,
	uart_byte_if.ctrl                  link,
	core_dbg_if.ctrl                   dbg,
	output logic                       col_start,
	output logic                       col_next,
	input  logic [dbg_pkg::data_w-1:0] col_byte
);
	import dbg_pkg::*;

	logic [st_w-1:0]             state;
	logic [pc_w:0]               load_left;
	logic [pc_w-1:0]             load_addr;
	logic [data_w-1:0]           hi_byte;
	logic [$clog2(dump_len)-1:0] dump_cnt;
	// One idle cycle so the core and collector settle before the first byte
	logic                        settle;
	logic                        tx_wait;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= st_idle;
			load_left     <= '0;
			load_addr     <= '0;
			hi_byte       <= '0;
			dump_cnt      <= '0;
			settle        <= 1'b0;
			tx_wait       <= 1'b0;
			dbg.imem_we   <= 1'b0;
			dbg.imem_addr <= '0;
			dbg.imem_data <= '0;
			dbg.core_clr  <= 1'b0;
			dbg.run_en    <= 1'b0;
			col_start     <= 1'b0;
			col_next      <= 1'b0;
			link.tx_start <= 1'b0;
			link.tx_data  <= '0;
		end else begin
			// Strobes last one cycle
			dbg.imem_we   <= 1'b0;
			dbg.core_clr  <= 1'b0;
			dbg.run_en    <= 1'b0;
			col_start     <= 1'b0;
			col_next      <= 1'b0;
			link.tx_start <= 1'b0;
			case (state)
				st_idle: begin
					if (link.rx_done) begin
						case (link.rx_data)
							cmd_load: begin
								dbg.core_clr <= 1'b1;
								state        <= st_ld_cnt;
							end
							cmd_run:  state <= st_run;
							cmd_step: state <= st_step;
							default:  state <= st_bad;
						endcase
					end
				end
				// ####################
				// Program load
				st_ld_cnt: begin
					if (link.rx_done) begin
						load_addr <= '0;
						if (link.rx_data == '0)
							state <= st_idle;
						else begin
							if (link.rx_data > imem_depth)
								load_left <= (pc_w + 1)'(imem_depth);
							else
								load_left <= link.rx_data[pc_w:0];
							state <= st_ld_hi;
						end
					end
				end
				st_ld_hi: begin
					if (link.rx_done) begin
						hi_byte <= link.rx_data;
						state   <= st_ld_lo;
					end
				end
				st_ld_lo: begin
					if (link.rx_done) begin
						dbg.imem_we   <= 1'b1;
						dbg.imem_addr <= load_addr;
						dbg.imem_data <= {hi_byte, link.rx_data};
						load_addr     <= load_addr + 1'b1;
						load_left     <= load_left - 1'b1;
						state         <= (load_left == 1) ? st_idle : st_ld_hi;
					end
				end
				// ####################
				// Execution
				st_run: begin
					if (dbg.halted) begin
						col_start <= 1'b1;
						settle    <= 1'b1;
						dump_cnt  <= '0;
						state     <= st_dump;
					end else begin
						dbg.run_en <= 1'b1;
					end
				end
				st_step: begin
					dbg.run_en <= 1'b1;
					col_start  <= 1'b1;
					settle     <= 1'b1;
					dump_cnt   <= '0;
					state      <= st_dump;
				end
				// ####################
				// Replies
				st_dump: begin
					if (settle) begin
						settle <= 1'b0;
					end else if (!tx_wait) begin
						link.tx_start <= 1'b1;
						link.tx_data  <= col_byte;
						col_next      <= 1'b1;
						tx_wait       <= 1'b1;
					end else if (link.tx_done) begin
						tx_wait <= 1'b0;
						if (dump_cnt == dump_len - 1)
							state <= st_idle;
						else
							dump_cnt <= dump_cnt + 1'b1;
					end
				end
				st_bad: begin
					if (!tx_wait) begin
						link.tx_start <= 1'b1;
						link.tx_data  <= resp_bad;
						tx_wait       <= 1'b1;
					end else if (link.tx_done) begin
						tx_wait <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/debug_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module debug_top (
	input  logic clk,
	input  logic arst_n,
	input  logic uart_rxd,
	output logic uart_txd
);
	import dbg_pkg::*;

	uart_byte_if u_byte_if ();
	core_dbg_if  u_core_if ();

	// Collector handshake and register read port
	logic              col_start;
	logic              col_next;
	logic [data_w-1:0] col_byte;
	logic [reg_aw-1:0] rd_idx;
	logic [data_w-1:0] rd_val;

	uart_rx u_uart_rx (.clk(clk), .arst_n(arst_n), .rx(uart_rxd), .link(u_byte_if.rx));

	uart_tx u_uart_tx (.clk(clk), .arst_n(arst_n), .tx(uart_txd), .link(u_byte_if.tx));

	mini_cpu u_mini_cpu (
		.clk(clk), .arst_n(arst_n), .dbg(u_core_if.core), .rd_idx(rd_idx), .rd_val(rd_val)
	);

	reg_collector u_reg_collector (
		.clk(clk), .arst_n(arst_n), .start(col_start), .next(col_next), .pc(u_core_if.pc),
		.rd_idx(rd_idx), .rd_val(rd_val), .byte_out(col_byte)
	);

	debug_fsm u_debug_fsm (
		.clk(clk), .arst_n(arst_n), .link(u_byte_if.ctrl), .dbg(u_core_if.ctrl),
		.col_start(col_start), .col_next(col_next), .col_byte(col_byte)
	);

endmodule

`default_nettype wire

// ==== bench/tb_debug_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_debug_top;
	import dbg_pkg::*;

	localparam int n_entries = 14;
	localparam int max_cmd   = 24;

	logic clk = 1'b0;
	logic arst_n;
	logic uart_rxd;
	logic uart_txd;

	// Command bytes and expected reply per table entry
	logic [7:0] cmd_tab [n_entries][max_cmd];
	int         cmd_len [n_entries];
	logic [7:0] rsp_tab [n_entries][dump_len];
	int         rsp_len [n_entries];

	logic [7:0] rx_q [$];
	int         cycle_cnt   = 0;
	int         cycle_limit = 2000;

	debug_top i_dut (.clk(clk), .arst_n(arst_n), .uart_rxd(uart_rxd), .uart_txd(uart_txd));

	always #20 clk = ~clk;

	// ####################
	// Table building
	function automatic logic [15:0] enc_reg(input logic [3:0] op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [2:0] rt);
		instr_t w;
		w = '0;
		w.r_fmt.op = op;
		w.r_fmt.rd = rd;
		w.r_fmt.rs = rs;
		w.r_fmt.rt = rt;
		return w;
	endfunction

	function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [2:0] rd,
		input logic [7:0] imm);
		instr_t w;
		w = '0;
		w.i_fmt.op  = op;
		w.i_fmt.rd  = rd;
		w.i_fmt.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic put_cmd(input int e, input logic [7:0] b);
		cmd_tab[e][cmd_len[e]] = b;
		cmd_len[e]++;
	endtask

	task automatic put_word(input int e, input logic [15:0] w);
		// High byte goes first
		put_cmd(e, w[15:8]);
		put_cmd(e, w[7:0]);
	endtask

	task automatic put_reply(input int e, input logic [7:0] b);
		rsp_tab[e][rsp_len[e]] = b;
		rsp_len[e]++;
	endtask

	// Registers packed r0 in the top byte down to r7
	task automatic put_dump(input int e, input logic [7:0] pc, input logic [63:0] regs);
		put_reply(e, pc);
		for (int i = 0; i < 8; i++)
			put_reply(e, regs[63 - 8*i -: 8]);
	endtask

	task automatic build_table();
		logic [31:0] seed;
		logic [7:0]  op_a;
		logic [7:0]  op_b;
		logic [7:0]  sum;
		for (int e = 0; e < n_entries; e++) begin
			cmd_len[e] = 0;
			rsp_len[e] = 0;
		end
		// All five register operations on 5A and 3C
		put_cmd(0, cmd_load);
		put_cmd(0, 8'd8);
		put_word(0, enc_imm(op_li, 3'd1, 8'h5A));
		put_word(0, enc_imm(op_li, 3'd2, 8'h3C));
		put_word(0, enc_reg(op_add, 3'd3, 3'd1, 3'd2));
		put_word(0, enc_reg(op_sub, 3'd4, 3'd2, 3'd1));
		put_word(0, enc_reg(op_and, 3'd5, 3'd1, 3'd2));
		put_word(0, enc_reg(op_or, 3'd6, 3'd1, 3'd2));
		put_word(0, enc_reg(op_xor, 3'd7, 3'd1, 3'd2));
		put_word(0, enc_reg(op_halt, 3'd0, 3'd0, 3'd0));
		put_cmd(1, cmd_run);
		put_dump(1, 8'd7, 64'h00_5A_3C_96_E2_18_7E_66);
		// Halted core stays put
		put_cmd(2, cmd_run);
		put_dump(2, 8'd7, 64'h00_5A_3C_96_E2_18_7E_66);
		// Countdown of r1 from 3
		put_cmd(3, cmd_load);
		put_cmd(3, 8'd5);
		put_word(3, enc_imm(op_li, 3'd2, 8'h07));
		put_word(3, enc_imm(op_li, 3'd1, 8'h03));
		put_word(3, enc_imm(op_addi, 3'd1, 8'hFF));
		put_word(3, enc_imm(op_bnz, 3'd1, 8'h02));
		put_word(3, enc_reg(op_halt, 3'd0, 3'd0, 3'd0));
		put_cmd(4, cmd_run);
		put_dump(4, 8'd4, 64'h00_00_07_00_00_00_00_00);
		// Three single steps with addi wrapping 81 + 90 to 11
		put_cmd(5, cmd_load);
		put_cmd(5, 8'd4);
		put_word(5, enc_imm(op_li, 3'd3, 8'h81));
		put_word(5, enc_imm(op_addi, 3'd3, 8'h90));
		put_word(5, enc_imm(op_li, 3'd6, 8'hC4));
		put_word(5, enc_reg(op_halt, 3'd0, 3'd0, 3'd0));
		put_cmd(6, cmd_step);
		put_dump(6, 8'd1, 64'h00_00_00_81_00_00_00_00);
		put_cmd(7, cmd_step);
		put_dump(7, 8'd2, 64'h00_00_00_11_00_00_00_00);
		put_cmd(8, cmd_step);
		put_dump(8, 8'd3, 64'h00_00_00_11_00_00_C4_00);
		put_cmd(9, 8'h3F);
		put_reply(9, resp_bad);
		// Undefined opcodes 9 and 0 act as no-ops
		put_cmd(10, cmd_load);
		put_cmd(10, 8'd2);
		put_word(10, 16'h9FFF);
		put_word(10, 16'h0000);
		put_cmd(11, cmd_step);
		put_dump(11, 8'd1, 64'h0);
		// Random operands summed into r5
		seed = lcg_step(32'hb84b8c8c);
		op_a = seed[23:16];
		seed = lcg_step(seed);
		op_b = seed[23:16];
		sum  = op_a + op_b;
		put_cmd(12, cmd_load);
		put_cmd(12, 8'd4);
		put_word(12, enc_imm(op_li, 3'd1, op_a));
		put_word(12, enc_imm(op_li, 3'd2, op_b));
		put_word(12, enc_reg(op_add, 3'd5, 3'd1, 3'd2));
		put_word(12, enc_reg(op_halt, 3'd0, 3'd0, 3'd0));
		put_cmd(13, cmd_run);
		put_dump(13, 8'd3, {8'h00, op_a, op_b, 16'h0, sum, 16'h0});
	endtask

	// ####################
	// Serial host model
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			uart_rxd = frame[i];
			repeat (clks_per_bit - 1) @(posedge clk);
		end
	endtask

	// Each bit is read near its middle on a falling clock edge
	task automatic recv_byte(output logic [7:0] b, output logic stop_ok);
		b = '0;
		@(negedge clk);
		while (uart_txd !== 1'b0)
			@(negedge clk);
		repeat (clks_per_bit / 2 - 1) @(negedge clk);
		for (int i = 0; i < data_w; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			b[i] = uart_txd;
		end
		repeat (clks_per_bit) @(negedge clk);
		stop_ok = (uart_txd === 1'b1);
	endtask

	task automatic wait_reply(output logic [7:0] b, output logic ok);
		int n;
		n  = 0;
		b  = '0;
		ok = 1'b0;
		while (rx_q.size() == 0 && n < 20 * clks_per_bit) begin
			@(posedge clk);
			n++;
		end
		if (rx_q.size() != 0) begin
			b  = rx_q.pop_front();
			ok = 1'b1;
		end
	endtask

	initial begin : tx_monitor
		logic [7:0] b;
		logic       framed;
		forever begin
			recv_byte(b, framed);
			assert (framed) else begin
				$display("Reply byte from the DUT ended without a stop bit");
				$display("STATUS: FAIL");
				$fatal(1, "framing error on uart_txd");
			end
			rx_q.push_back(b);
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		assert (cycle_cnt < cycle_limit) else begin
			$display("Simulation ran out of time after %0d cycles", cycle_cnt);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	// ####################
	// Main sequence
	initial begin
		logic [7:0] got;
		logic       arrived;
		int         total;
		arst_n   = 1'b0;
		uart_rxd = 1'b1;
		build_table();
		total = 0;
		for (int e = 0; e < n_entries; e++)
			total += cmd_len[e] + rsp_len[e];
		cycle_limit = total * 10 * clks_per_bit * 3 + 2000;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		for (int e = 0; e < n_entries; e++) begin
			for (int k = 0; k < cmd_len[e]; k++)
				send_byte(cmd_tab[e][k]);
			for (int k = 0; k < rsp_len[e]; k++) begin
				wait_reply(got, arrived);
				assert (arrived) else begin
					$display("Reply byte %0d of entry %0d never arrived", k, e);
					$display("STATUS: FAIL");
					$fatal(1, "missing reply byte");
				end
				assert (got == rsp_tab[e][k]) else begin
					$display("[ERROR] %0t ns: entry %0d byte %0d expected %02h got %02h",
						$time, e, k, rsp_tab[e][k], got);
					$display("STATUS: FAIL");
					$fatal(1, "reply mismatch");
				end
			end
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/dbg_pkg.sv
verilog/dbg_ifs.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mini_cpu.sv
verilog/reg_collector.sv
verilog/debug_fsm.sv
verilog/debug_top.sv
bench/tb_debug_top.sv
